/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cart_system
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+include
verilog/cart_pkg.sv
verilog/clock_enables.sv
verilog/cart_loader.sv
verilog/rom_arbiter.sv
verilog/cheat_loader.sv
verilog/backup_sequencer.sv
verilog/cart_system_top.sv
dv/tb_cart_system.sv

/* include/tb_checks.svh */
// Compare tasks for bytes, flags, clock enables, cheat records and sector requests
// Failure reporting and the SD sector responder

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic end_with_failure();
	$display("Verification failed");
	$fatal(1, "stopping at the first error");
endtask

task automatic report_mismatch(input string what);
	$display("CHECK FAILED at time %0t: %s", $time, what);
	end_with_failure();
endtask

task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s: got %02h, expected %02h", what, got, exp));
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
endtask

task automatic check_ce(input ce_t got, input ce_t exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s: cpu/vdp/pix/sp got %04b, expected %04b",
			what, got, exp));
endtask

task automatic check_cheat(input cheat_code_t got, input cheat_code_t exp);
	if (got !== exp)
		report_mismatch($sformatf("cheat record: got %h %h %h %h, expected %h %h %h %h",
			got.fields.replace, got.fields.compare, got.fields.address, got.fields.flags,
			exp.fields.replace, exp.fields.compare, exp.fields.address, exp.fields.flags));
endtask

task automatic check_sd(input sd_req_t got, input sd_req_t exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s: lba %0d rd %b wr %b, expected lba %0d rd %b wr %b",
			what, got.lba, got.rd, got.wr, exp.lba, exp.rd, exp.wr));
endtask

// Acknowledge every sector of one load or save, in order
task automatic serve_sectors(input logic load);
	sd_req_t exp;
	int      i;
	for (i = 0; i < SECTORS; i++) begin
		while (!(sd_req.rd || sd_req.wr))
			@(negedge clk_sys);
		exp.lba = 32'(i);
		exp.rd = load;
		exp.wr = !load;
		check_sd(sd_req, exp, "sector request");
		if (load)
			check_flag(console_reset, 1'b1, "console_reset during backup load");
		sd_ack = 1'b1;
		@(negedge clk_sys);
		while (sd_req.rd || sd_req.wr)  // Request drops once ack is seen
			@(negedge clk_sys);
		sd_ack = 1'b0;  // Falling ack ends the sector
		@(negedge clk_sys);
	end
endtask

`endif

/* dv/tb_cart_system.sv */
// Testbench for the cartridge core
// Clock enables, cartridge downloads and ROM reads, cheat record, backup sequencing

`timescale 1ns/100ps

module tb_cart_system import cart_pkg::*; ();

	localparam int ROM_AW = 16;
	localparam int BK_SECTOR_BITS = 6;
	localparam int SECTORS = 2 ** BK_SECTOR_BITS;
	localparam int SMALL_LEN = 16;
	// Cart bytes take 3 cycles, reads 2, sectors 2, plus slack for setup
	localparam int TEST_CYCLES = 3 * (256 + 768 + 2 * SMALL_LEN + 16) + 2 * (512 + 256)
		+ 4 * SECTORS + 400;
	localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

	logic              clk_sys;
	logic              reset;
	ioctl_t            ioctl;
	logic              ioctl_download;
	logic              ioctl_wait;
	logic              rom_rd;
	logic [ROM_AW-1:0] rom_addr;
	logic [7:0]        rom_data;
	logic              rom_valid;
	logic              img_mounted;
	logic              img_readonly;
	logic              img_size_nz;
	logic              bk_load;
	logic              bk_save;
	logic              sd_ack;
	ce_t               ce;
	logic              handheld;
	cheat_code_t       cheat_code;
	logic              cheat_valid;
	sd_req_t           sd_req;
	logic              bk_busy;
	logic              console_reset;

	logic [7:0]        image [0:1023];  // Bytes sent by the host
	logic [ROM_AW-1:0] rd_addr_tab [0:511];
	logic [7:0]        rd_exp_tab [0:511];
	int                seed = 92;
	int unsigned       cycles = 0;

	`include "tb_checks.svh"

	cart_system_top #(.ROM_AW(ROM_AW), .BK_SECTOR_BITS(BK_SECTOR_BITS)) u_cart_system_top (
		.clk_sys (clk_sys), .reset (reset), .ioctl (ioctl),
		.ioctl_download (ioctl_download), .ioctl_wait (ioctl_wait),
		.rom_rd (rom_rd), .rom_addr (rom_addr), .rom_data (rom_data), .rom_valid (rom_valid),
		.img_mounted (img_mounted), .img_readonly (img_readonly), .img_size_nz (img_size_nz),
		.bk_load (bk_load), .bk_save (bk_save), .sd_ack (sd_ack), .ce (ce),
		.handheld (handheld), .cheat_code (cheat_code), .cheat_valid (cheat_valid),
		.sd_req (sd_req), .bk_busy (bk_busy), .console_reset (console_reset)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			end_with_failure();
		end
	end

	// ==================================================
	// Host side helpers
	// ==================================================
	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data, input logic hold);
		ioctl.wr = 1'b1;
		ioctl.addr = addr;
		ioctl.dout = data;
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
		while (ioctl_wait) begin
			if (hold)
				check_flag(console_reset, 1'b1, "console_reset during download");
			@(negedge clk_sys);
		end
	endtask

	task automatic download(input logic [7:0] index, input int len, input logic hold);
		int i;
		ioctl.index = index;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (i = 0; i < len; i++)
			send_byte(25'(i), image[i], hold);
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);  // Let the geometry settle
	endtask

	task automatic run_reads(input int n, input string what);
		logic [7:0] data;
		int         i;
		for (i = 0; i < n; i++) begin
			rom_rd = 1'b1;
			rom_addr = rd_addr_tab[i];
			@(negedge clk_sys);
			rom_rd = 1'b0;
			while (!rom_valid)
				@(negedge clk_sys);
			data = rom_data;
			check_byte(data, rd_exp_tab[i], $sformatf("%s read at %h", what, rd_addr_tab[i]));
		end
	endtask

	task automatic expect_idle(input int n, input string what);
		int i;
		for (i = 0; i < n; i++) begin
			check_flag(bk_busy, 1'b0, what);
			check_flag(sd_req.rd | sd_req.wr, 1'b0, what);
			@(negedge clk_sys);
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		ce_t         exp_ce;
		cheat_code_t exp_code;
		int          i;
		int          ph;

		reset = 1'b1;
		ioctl = '0;
		ioctl_download = 1'b0;
		rom_rd = 1'b0;
		rom_addr = '0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nz = 1'b0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		sd_ack = 1'b0;
		repeat (8) @(negedge clk_sys);
		check_flag(console_reset, 1'b1, "console_reset in reset");
		check_ce(ce, '0, "enables in reset");
		check_flag(ioctl_wait | rom_valid | cheat_valid | bk_busy, 1'b0, "status flags in reset");
		check_sd(sd_req, '0, "sector request in reset");
		reset = 1'b0;

		// Count 9 is the only phase with cpu and pix together
		while (!(ce.cpu && ce.pix))
			@(negedge clk_sys);
		for (i = 0; i < 3 * CE_PERIOD; i++) begin
			ph = (9 + i) % CE_PERIOD;
			exp_ce.cpu = (ph == 9) || (ph == 24);
			exp_ce.vdp = (ph % 5) == 4;
			exp_ce.pix = (ph % 10) == 9;
			exp_ce.sp = (ph % 2) == 1;
			check_ce(ce, exp_ce, $sformatf("enables at phase %0d", ph));
			@(negedge clk_sys);
		end

		// Plain cartridge mirrors every 256 bytes
		for (i = 0; i < 256; i++)
			image[i] = 8'(i) ^ 8'h5A;
		download(8'd1, 256, 1'b0);
		check_flag(handheld, 1'b0, "handheld after plain cartridge");
		for (i = 0; i < 512; i++) begin
			rd_addr_tab[i] = ROM_AW'(i);
			rd_exp_tab[i] = image[i % 256];
		end
		run_reads(512, "plain cartridge");

		// Copier header skipped, 256 byte body
		for (i = 0; i < 768; i++)
			image[i] = 8'($random(seed));
		download(HANDHELD_INDEX, 768, 1'b1);
		check_flag(handheld, 1'b1, "handheld after header cartridge");
		for (i = 0; i < 256; i++) begin
			rd_addr_tab[i] = ROM_AW'($random(seed));
			rd_exp_tab[i] = image[HEADER_BYTES + int'(rd_addr_tab[i]) % 256];
		end
		run_reads(256, "header cartridge");

		// Cheat record
		for (i = 0; i < 16; i++)
			image[i] = 8'($random(seed));
		ioctl.index = CHEAT_INDEX;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (i = 0; i < 16; i++)
			send_byte(25'(i), image[i], 1'b0);
		check_flag(cheat_valid, 1'b1, "cheat_valid after the last byte");
		exp_code.fields.flags = {image[3], image[2], image[1], image[0]};
		exp_code.fields.address = {image[7], image[6], image[5], image[4]};
		exp_code.fields.compare = {image[11], image[10], image[9], image[8]};
		exp_code.fields.replace = {image[15], image[14], image[13], image[12]};
		check_cheat(cheat_code, exp_code);
		ioctl_download = 1'b0;
		@(negedge clk_sys);

		// Writable backup image, auto load then save
		img_mounted = 1'b1;
		img_size_nz = 1'b1;
		download(8'd1, SMALL_LEN, 1'b1);
		serve_sectors(1'b1);
		while (bk_busy)
			@(negedge clk_sys);
		bk_save = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		serve_sectors(1'b0);
		while (bk_busy)
			@(negedge clk_sys);

		// Read-only image blocks both directions
		img_readonly = 1'b1;
		download(8'd1, SMALL_LEN, 1'b1);
		expect_idle(4, "no transfer after read-only download");
		bk_load = 1'b1;
		@(negedge clk_sys);
		bk_load = 1'b0;
		expect_idle(8, "no transfer on load with read-only image");
		bk_save = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		expect_idle(8, "no transfer on save with read-only image");

		$display("Verification passed");
		$finish;
	end

endmodule

/* verilog/backup_sequencer.sv */
// Backup RAM enable tracking
// Sector load and save sequencing over the SD request link

`timescale 1ns/100ps

module backup_sequencer import cart_pkg::*; #(
	parameter int BK_SECTOR_BITS = 6
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  load_evt_t load_evt,
	input  logic      img_mounted,
	input  logic      img_readonly,
	input  logic      img_size_nz,
	input  logic      bk_load,
	input  logic      bk_save,
	input  logic      sd_ack,
	output sd_req_t   sd_req,
	output logic      bk_busy,
	output logic      bk_loading
);

	logic bk_ena;
	logic ack_q;
	logic auto_load;
	logic do_load;
	logic kick;

	assign auto_load = load_evt.done & img_size_nz;
	assign do_load = bk_load | auto_load;
	assign kick = bk_ena & ~bk_busy & (do_load | bk_save);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena <= 1'b0;
			ack_q <= 1'b0;
			bk_busy <= 1'b0;
			bk_loading <= 1'b0;
			sd_req <= '0;
		end else begin
			ack_q <= sd_ack;

			// Save image is mounted while the cartridge downloads
			if (load_evt.start)
				bk_ena <= 1'b0;
			if (load_evt.active && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (sd_ack && !ack_q) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end

			// ==================================================
			// Sector sequence
			// ==================================================
			if (kick) begin
				bk_busy <= 1'b1;
				bk_loading <= do_load;
				sd_req.lba <= '0;
				sd_req.rd <= do_load;
				sd_req.wr <= ~do_load;
			end else if (bk_busy && ack_q && !sd_ack) begin
				if (&sd_req.lba[BK_SECTOR_BITS-1:0]) begin
					bk_busy <= 1'b0;  // Last sector done
					bk_loading <= 1'b0;
				end else begin
					sd_req.lba <= sd_req.lba + 32'd1;
					sd_req.rd <= bk_loading;
					sd_req.wr <= ~bk_loading;
				end
			end
		end
	end

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_req.rd && sd_req.wr));

endmodule

/* verilog/cart_loader.sv */
// Cartridge download handshake and ROM write address
// Size masks, copier header detection and download events

`timescale 1ns/100ps

module cart_loader import cart_pkg::*; #(
	parameter int ROM_AW = 16
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  ioctl_t     ioctl,
	input  logic       cart_dl,
	input  logic       wr_done,
	output logic       ioctl_wait,
	output rom_wr_t    rom_wr,
	output cart_geom_t geom,
	output load_evt_t  load_evt,
	output logic       handheld
);

	logic                  dl_q;
	logic                  last_a9;  // Bit 9 of the last written address
	logic                  wr_hit;
	logic [ROM_AW-1:0]     wr_addr;
	logic [ROM_AW-1:0]     wr_ptr;
	logic [MAX_ROM_AW-1:0] hdr_off;

	// ==================================================
	// Download events
	// ==================================================
	assign load_evt.active = cart_dl;
	assign load_evt.start = cart_dl & ~dl_q;
	assign load_evt.done = dl_q & ~cart_dl;

	assign wr_hit = ioctl.wr & cart_dl;
	assign wr_ptr = load_evt.start ? '0 : wr_addr;  // First byte may land on start
	assign hdr_off = ioctl.addr[MAX_ROM_AW-1:0] - MAX_ROM_AW'(HEADER_BYTES);

	always_ff @(posedge clk_sys) begin
		if (wr_hit) begin
			rom_wr.addr <= MAX_ROM_AW'(wr_ptr);
			rom_wr.data <= ioctl.dout;
			last_a9 <= ioctl.addr[9];
			geom.mask <= (ioctl.addr == '0) ? '0 : geom.mask | ioctl.addr[MAX_ROM_AW-1:0];
			geom.mask512 <= (ioctl.addr == HEADER_BYTES) ? '0 : geom.mask512 | hdr_off;
		end

		if (reset) begin
			dl_q <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_wr.strobe <= 1'b0;
			wr_addr <= '0;
			handheld <= 1'b0;
			geom.sz512 <= 1'b0;
		end else begin
			dl_q <= cart_dl;
			rom_wr.strobe <= wr_hit;
			if (load_evt.start)
				wr_addr <= '0;
			if (load_evt.done)
				geom.sz512 <= last_a9;  // Odd 512 blocks mean a copier header

			if (wr_hit) begin
				ioctl_wait <= 1'b1;
				handheld <= ioctl.index == HANDHELD_INDEX;
			end else if (ioctl_wait && wr_done) begin
				ioctl_wait <= 1'b0;
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

endmodule

/* verilog/cart_pkg.sv */
// Shared constants for the cartridge core
// Clock enable, download bus, ROM write and sector request structs
// Cheat record union with byte and field views

package cart_pkg;

	localparam int CE_PERIOD = 30;
	localparam int HEADER_BYTES = 512;
	localparam logic [7:0] CHEAT_INDEX = 8'hFF;
	localparam logic [7:0] HANDHELD_INDEX = 8'd2;
	localparam int MAX_ROM_AW = 22;

	typedef struct packed {
		logic cpu;
		logic vdp;
		logic pix;
		logic sp;
	} ce_t;

	// Host download bus
	typedef struct packed {
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  dout;
		logic [7:0]  index;
	} ioctl_t;

	typedef struct packed {
		logic active;
		logic start;
		logic done;
	} load_evt_t;

	typedef struct packed {
		logic [MAX_ROM_AW-1:0] mask;
		logic [MAX_ROM_AW-1:0] mask512;  // Mask with copier header removed
		logic                  sz512;
	} cart_geom_t;

	typedef struct packed {
		logic                  strobe;
		logic [MAX_ROM_AW-1:0] addr;
		logic [7:0]            data;
	} rom_wr_t;

	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	// Most significant field first
	typedef struct packed {
		logic [31:0] replace;
		logic [31:0] compare;
		logic [31:0] address;
		logic [31:0] flags;
	} cheat_fields_t;

	// Lane k holds download offset k
	typedef union packed {
		logic [15:0][7:0] lanes;
		cheat_fields_t    fields;
	} cheat_code_t;

endpackage

/* verilog/cart_system_top.sv */
// Cartridge core top level
// Download split by index, ROM arbiter hookup and console reset

`timescale 1ns/100ps

module cart_system_top import cart_pkg::*; #(
	parameter int ROM_AW = 16,
	parameter int BK_SECTOR_BITS = 6
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  ioctl_t            ioctl,
	input  logic              ioctl_download,
	output logic              ioctl_wait,
	input  logic              rom_rd,
	input  logic [ROM_AW-1:0] rom_addr,
	output logic [7:0]        rom_data,
	output logic              rom_valid,
	input  logic              img_mounted,
	input  logic              img_readonly,
	input  logic              img_size_nz,
	input  logic              bk_load,
	input  logic              bk_save,
	input  logic              sd_ack,
	output ce_t               ce,
	output logic              handheld,
	output cheat_code_t       cheat_code,
	output logic              cheat_valid,
	output sd_req_t           sd_req,
	output logic              bk_busy,
	output logic              console_reset
);

	logic       cart_dl;
	logic       cheat_dl;
	logic       wr_done;
	logic       bk_loading;
	rom_wr_t    rom_wr;
	cart_geom_t geom;
	load_evt_t  load_evt;

	// Cheat records use the all ones index
	assign cheat_dl = ioctl_download & (ioctl.index == CHEAT_INDEX);
	assign cart_dl = ioctl_download & (ioctl.index != CHEAT_INDEX);

	// Hold the console while the cartridge or backup RAM is loading
	assign console_reset = reset | load_evt.active | bk_loading;

	clock_enables u_clock_enables (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce      (ce)
	);

	cart_loader #(.ROM_AW(ROM_AW)) u_cart_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ioctl      (ioctl),
		.cart_dl    (cart_dl),
		.wr_done    (wr_done),
		.ioctl_wait (ioctl_wait),
		.rom_wr     (rom_wr),
		.geom       (geom),
		.load_evt   (load_evt),
		.handheld   (handheld)
	);

	rom_arbiter #(.ROM_AW(ROM_AW)) u_rom_arbiter (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.rom_wr    (rom_wr),
		.geom      (geom),
		.rom_rd    (rom_rd),
		.rom_addr  (rom_addr),
		.wr_done   (wr_done),
		.rom_data  (rom_data),
		.rom_valid (rom_valid)
	);

	cheat_loader u_cheat_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl       (ioctl),
		.cheat_dl    (cheat_dl),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	backup_sequencer #(.BK_SECTOR_BITS(BK_SECTOR_BITS)) u_backup_sequencer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.load_evt     (load_evt),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.sd_ack       (sd_ack),
		.sd_req       (sd_req),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading)
	);

endmodule

/* verilog/cheat_loader.sv */
// Cheat record assembly from the cheat download stream

`timescale 1ns/100ps

module cheat_loader import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  ioctl_t      ioctl,
	input  logic        cheat_dl,
	output cheat_code_t cheat_code,
	output logic        cheat_valid
);

	logic       code_wr;
	logic [3:0] lane;

	assign code_wr = cheat_dl & ioctl.wr;
	assign lane = ioctl.addr[3:0];

	always_ff @(posedge clk_sys) begin
		if (code_wr)
			cheat_code.lanes[lane] <= ioctl.dout;

		if (reset)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= code_wr && lane == 4'hF;  // Last byte completes the record
	end

endmodule

/* verilog/clock_enables.sv */
// CPU, VDP, pixel and sprite clock enables
// from one 30-cycle phase counter

`timescale 1ns/100ps

module clock_enables import cart_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	output ce_t  ce
);

	logic [$clog2(CE_PERIOD)-1:0] cnt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt <= '0;
			ce <= '0;
		end else begin
			cnt <= (cnt == CE_PERIOD - 1) ? '0 : cnt + 1'b1;
			ce.sp <= cnt[0];  // Half rate
			ce.cpu <= 1'b0;
			ce.vdp <= 1'b0;
			ce.pix <= 1'b0;
			case (cnt)
				4, 14: ce.vdp <= 1'b1;
				9: begin
					ce.cpu <= 1'b1;
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
				end
				19, 29: begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
				end
				24: begin
					ce.cpu <= 1'b1;  // Late CPU phase
					ce.vdp <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	a_cnt_range: assert property (@(posedge clk_sys) disable iff (reset)
		cnt <= CE_PERIOD - 1);

endmodule

/* verilog/rom_arbiter.sv */
// Cartridge ROM array shared by loader writes and console reads
// Write priority, one-deep read slot and mirrored read address

`timescale 1ns/100ps

module rom_arbiter import cart_pkg::*; #(
	parameter int ROM_AW = 16
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  rom_wr_t           rom_wr,
	input  cart_geom_t        geom,
	input  logic              rom_rd,
	input  logic [ROM_AW-1:0] rom_addr,
	output logic              wr_done,
	output logic [7:0]        rom_data,
	output logic              rom_valid
);

	logic [7:0] rom [2**ROM_AW];

	logic              rd_q;       // Read in the RAM stage
	logic [ROM_AW-1:0] addr_q;
	logic              slot_full;
	logic [ROM_AW-1:0] slot_addr;
	logic [ROM_AW-1:0] hdr_addr;
	logic [ROM_AW-1:0] plain_addr;
	logic [ROM_AW-1:0] map_addr;
	logic [ROM_AW-1:0] rd_addr;
	logic              rd_go;

	// ==================================================
	// Console address mapping
	// ==================================================
	assign hdr_addr = (rom_addr & geom.mask512[ROM_AW-1:0]) + ROM_AW'(HEADER_BYTES);
	assign plain_addr = rom_addr & geom.mask[ROM_AW-1:0];
	assign map_addr = geom.sz512 ? hdr_addr : plain_addr;

	// Stored read goes first so data returns in order
	assign rd_addr = slot_full ? slot_addr : addr_q;
	assign rd_go = (slot_full | rd_q) & ~rom_wr.strobe;

	always_ff @(posedge clk_sys) begin
		if (rom_wr.strobe)
			rom[rom_wr.addr[ROM_AW-1:0]] <= rom_wr.data;
		else if (rd_go)
			rom_data <= rom[rd_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (rom_rd)
			addr_q <= map_addr;
		// Stage read parks behind a blocked or draining slot
		if (rd_q && (rom_wr.strobe ? !slot_full : slot_full))
			slot_addr <= addr_q;

		if (reset) begin
			rd_q <= 1'b0;
			slot_full <= 1'b0;
			rom_valid <= 1'b0;
			wr_done <= 1'b0;
		end else begin
			rd_q <= rom_rd;
			rom_valid <= rd_go;
			wr_done <= rom_wr.strobe;  // Byte stored this cycle
			if (rom_wr.strobe)
				slot_full <= slot_full | rd_q;
			else if (slot_full)
				slot_full <= rd_q;
		end
	end

	a_slot_no_rd: assert property (@(posedge clk_sys) disable iff (reset)
		slot_full |-> !rom_rd);

endmodule
